//--- rtl/tmu_config.svh
//##########################################################
// Build-time sizes for the span rasterizer of the texture unit
// Pull this header in wherever a width or a cycle count is needed
//##########################################################

`ifndef TMU_CONFIG_SVH
`define TMU_CONFIG_SVH

// Width of every screen and texture coordinate, two's complement
// Coordinates stay within 0 to 1023, the extra bit carries the sign of differences
`define TMU_COORD_W 12

// Width of divisor, quotient and remainder
// Span lengths and texture deltas never exceed 1023 in magnitude
`define TMU_FRAC_W 11

// The serial divider retires one quotient bit per clock
// So a full division takes as many cycles as the quotient is wide
`define TMU_DIV_CYCLES `TMU_FRAC_W

`endif

//--- rtl/tmu_geom_pkg.sv
//##########################################################
// Geometry types for the span rasterizer
// Spans come in, step words go to the tracer, points go out
//##########################################################

`include "tmu_config.svh"

package tmu_geom_pkg;

	// One signed coordinate on screen or in texture space
	typedef logic signed [`TMU_COORD_W-1:0] tmu_coord_t;

	// Unsigned magnitude as seen by the divider
	typedef logic [`TMU_FRAC_W-1:0] tmu_frac_t;

	// A horizontal span with texture coordinates at both ends
	// Start X must not lie right of end X
	typedef struct packed {
		tmu_coord_t y;
		tmu_coord_t s_x;
		tmu_coord_t s_u;
		tmu_coord_t s_v;
		tmu_coord_t e_x;
		tmu_coord_t e_u;
		tmu_coord_t e_v;
	} tmu_span_t;

	// Per-pixel step along one texture axis
	// The remainder feeds the error accumulator of the tracer
	typedef struct packed {
		logic      positive;
		tmu_frac_t q;
		tmu_frac_t r;
	} tmu_step_t;

	// Everything the tracer needs to walk one span
	typedef struct packed {
		tmu_coord_t y;
		tmu_coord_t s_x;
		tmu_coord_t s_u;
		tmu_coord_t s_v;
		tmu_coord_t e_x;
		tmu_step_t  du;
		tmu_step_t  dv;
		tmu_frac_t  divisor;
	} tmu_trace_t;

	// One textured pixel leaving the stage
	typedef struct packed {
		tmu_coord_t x;
		tmu_coord_t y;
		tmu_coord_t u;
		tmu_coord_t v;
	} tmu_point_t;

endpackage

//--- rtl/tmu_ctrl_pkg.sv
//##########################################################
// Controller state encodings of the span rasterizer
// Shared by the setup block and the scan tracer
//##########################################################

package tmu_ctrl_pkg;

	// Setup block sequence
	// Idle takes a span, divide waits on both dividers, handoff waits on the tracer
	typedef enum logic [1:0] {
		SETUP_IDLE    = 2'd0,
		SETUP_DIVIDE  = 2'd1,
		SETUP_HANDOFF = 2'd2
	} tmu_setup_state_e;

	// Scan tracer sequence
	// Busy lasts from the load until the last point is acknowledged
	typedef enum logic [0:0] {
		TRACE_IDLE = 1'b0,
		TRACE_BUSY = 1'b1
	} tmu_trace_state_e;

endpackage

//--- rtl/tmu_divider.sv
//##########################################################
// Serial restoring divider, one quotient bit per clock
// Pulse start with the operands, results follow with done
// and hold until the next start
//##########################################################

`timescale 1ns/100ps
`include "tmu_config.svh"

module tmu_divider #(
	parameter int width = `TMU_FRAC_W
) (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic             start,
	input  logic [width-1:0] dividend,
	input  logic [width-1:0] divisor,
	output logic [width-1:0] quotient,
	output logic [width-1:0] remainder,
	output logic             done
);

	localparam int cnt_w = $clog2(`TMU_DIV_CYCLES + 1);

	// Dividend bits leave at the top while quotient bits enter at the bottom
	logic [width-1:0] quo_q;
	logic [width-1:0] rem_q;
	logic [width-1:0] div_q;
	logic [cnt_w-1:0] cnt_q;
	logic             running;

	logic             iterate;
	logic [width-1:0] quo_src;
	logic [width-1:0] rem_src;
	logic [width-1:0] div_src;
	logic [width:0]   trial;
	logic [width+1:0] diff;

	// The first iteration runs on the start edge, directly from the inputs
	assign iterate = start | running;
	assign quo_src = start ? dividend : quo_q;
	assign rem_src = start ? '0 : rem_q;
	assign div_src = start ? divisor : div_q;

	// Shift the next dividend bit into the partial remainder and try the subtraction
	assign trial = {rem_src, quo_src[width-1]};
	assign diff = {1'b0, trial} - {2'b00, div_src};

	// A borrow means the divisor did not fit and the trial value is kept
	always_ff @(posedge sys_clk) begin
		if (iterate) begin
			div_q <= div_src;
			if (diff[width+1]) begin
				rem_q <= trial[width-1:0];
				quo_q <= {quo_src[width-2:0], 1'b0};
			end else begin
				rem_q <= diff[width-1:0];
				quo_q <= {quo_src[width-2:0], 1'b1};
			end
		end
	end

	// Counts the iterations still left after the one done on the start edge
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			running <= 1'b0;
			cnt_q   <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				cnt_q   <= cnt_w'(`TMU_DIV_CYCLES - 1);
			end else if (running) begin
				cnt_q <= cnt_q - 1'b1;
				if (cnt_q == cnt_w'(1)) begin
					// Last bit retires on this edge
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	assign quotient = quo_q;
	assign remainder = rem_q;

endmodule

//--- rtl/tmu_span_setup.sv
//##########################################################
// Span setup for the rasterizer
// Takes a span, derives length and texture deltas, runs the
// two dividers and passes a complete step word to the tracer
//##########################################################

`timescale 1ns/100ps
`include "tmu_config.svh"

module tmu_span_setup (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      span_stb,
	output logic                      span_ack,
	input  tmu_geom_pkg::tmu_span_t   span,
	output logic                      div_start,
	output tmu_geom_pkg::tmu_frac_t   du_dividend,
	output tmu_geom_pkg::tmu_frac_t   dv_dividend,
	output tmu_geom_pkg::tmu_frac_t   divisor,
	input  tmu_geom_pkg::tmu_frac_t   du_q,
	input  tmu_geom_pkg::tmu_frac_t   du_r,
	input  tmu_geom_pkg::tmu_frac_t   dv_q,
	input  tmu_geom_pkg::tmu_frac_t   dv_r,
	input  logic                      div_done,
	output logic                      trace_stb,
	input  logic                      trace_ack,
	output tmu_geom_pkg::tmu_trace_t  trace,
	output logic                      busy
);
	import tmu_geom_pkg::*;
	import tmu_ctrl_pkg::*;

	tmu_setup_state_e state;
	tmu_setup_state_e state_next;
	tmu_span_t        span_q;
	logic             accept;
	logic             accept_d;
	tmu_coord_t       dx_diff;
	tmu_coord_t       du_diff;
	tmu_coord_t       dv_diff;
	logic             du_positive;
	logic             dv_positive;

	// Magnitude of a signed difference, cut down to divider width
	function automatic tmu_frac_t magnitude(input tmu_coord_t d);
		tmu_coord_t mag;
		mag = d[`TMU_COORD_W-1] ? -d : d;
		return mag[`TMU_FRAC_W-1:0];
	endfunction

	// A span is only taken while the controller sits idle
	assign span_ack = (state == SETUP_IDLE);
	assign accept = span_stb & span_ack;

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			span_q <= span;
		end
	end

	// Differences from the registered span, settled one cycle after acceptance
	assign dx_diff = span_q.e_x - span_q.s_x;
	assign du_diff = span_q.e_u - span_q.s_u;
	assign dv_diff = span_q.e_v - span_q.s_v;

	// Divider operands are captured together with the start pulse
	// A flat slope counts as positive and divides to zero
	always_ff @(posedge sys_clk) begin
		if (accept_d) begin
			divisor     <= dx_diff[`TMU_FRAC_W-1:0];
			du_positive <= ~du_diff[`TMU_COORD_W-1];
			dv_positive <= ~dv_diff[`TMU_COORD_W-1];
			du_dividend <= magnitude(du_diff);
			dv_dividend <= magnitude(dv_diff);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state     <= SETUP_IDLE;
			accept_d  <= 1'b0;
			div_start <= 1'b0;
		end else begin
			state     <= state_next;
			accept_d  <= accept;
			div_start <= accept_d;
		end
	end

	// Both dividers run in lockstep, so the U divider's done speaks for both
	always_comb begin
		state_next = state;
		case (state)
			SETUP_IDLE: begin
				if (span_stb) begin
					state_next = SETUP_DIVIDE;
				end
			end
			SETUP_DIVIDE: begin
				if (div_done) begin
					state_next = SETUP_HANDOFF;
				end
			end
			SETUP_HANDOFF: begin
				if (trace_ack) begin
					state_next = SETUP_IDLE;
				end
			end
			default: begin
				state_next = SETUP_IDLE;
			end
		endcase
	end

	// The step word is stable for the whole handoff
	always_comb begin
		trace.y           = span_q.y;
		trace.s_x         = span_q.s_x;
		trace.s_u         = span_q.s_u;
		trace.s_v         = span_q.s_v;
		trace.e_x         = span_q.e_x;
		trace.du.positive = du_positive;
		trace.du.q        = du_q;
		trace.du.r        = du_r;
		trace.dv.positive = dv_positive;
		trace.dv.q        = dv_q;
		trace.dv.r        = dv_r;
		trace.divisor     = divisor;
	end

	assign trace_stb = (state == SETUP_HANDOFF);
	assign busy = (state != SETUP_IDLE);

endmodule

//--- rtl/tmu_scantrace.sv
//##########################################################
// Scan tracer of the rasterizer
// Walks a span from start X to end X and emits one textured
// point per pixel, interpolating U and V with error terms
//##########################################################

`timescale 1ns/100ps
`include "tmu_config.svh"

module tmu_scantrace (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      trace_stb,
	output logic                      trace_ack,
	input  tmu_geom_pkg::tmu_trace_t  trace,
	output logic                      point_stb,
	input  logic                      point_ack,
	output tmu_geom_pkg::tmu_point_t  point,
	output logic                      busy
);
	import tmu_geom_pkg::*;
	import tmu_ctrl_pkg::*;

	// One bit wider than the remainder so a negative error shows in the top bit
	typedef logic [`TMU_FRAC_W:0] err_t;

	tmu_trace_state_e state;
	tmu_trace_state_e state_next;
	logic             load;
	logic             advance;
	logic             last;
	tmu_coord_t       e_x_q;
	tmu_step_t        du_q;
	tmu_step_t        dv_q;
	tmu_frac_t        divisor_q;
	err_t             err_u;
	err_t             err_v;
	err_t             err_u_next;
	err_t             err_v_next;
	tmu_coord_t       u_next;
	tmu_coord_t       v_next;

	// Advances one texture axis by a single pixel
	// The extra unit is taken once the accumulated remainder passes half the divisor
	function automatic void step_axis(
		input  tmu_coord_t coord,
		input  err_t       err,
		input  tmu_step_t  axis_step,
		input  tmu_frac_t  div_len,
		output tmu_coord_t coord_next,
		output err_t       err_next
	);
		err_t       sum;
		logic       correct;
		tmu_coord_t delta;
		sum = err + err_t'(axis_step.r);
		correct = ~sum[`TMU_FRAC_W] && (sum[`TMU_FRAC_W-1:0] > (div_len >> 1));
		delta = tmu_coord_t'(axis_step.q) + tmu_coord_t'(correct);
		coord_next = axis_step.positive ? coord + delta : coord - delta;
		err_next = correct ? sum - err_t'(div_len) : sum;
	endfunction

	// The point on display is the last one once X has reached the end
	assign last = (point.x == e_x_q);
	assign load = (state == TRACE_IDLE) & trace_stb;
	assign advance = (state == TRACE_BUSY) & point_ack & ~last;

	always_comb begin
		step_axis(point.u, err_u, du_q, divisor_q, u_next, err_u_next);
		step_axis(point.v, err_v, dv_q, divisor_q, v_next, err_v_next);
	end

	// Point and step registers only move on a load or an acknowledged point
	// So the output holds still while the consumer stalls
	always_ff @(posedge sys_clk) begin
		if (load) begin
			point.x   <= trace.s_x;
			point.y   <= trace.y;
			point.u   <= trace.s_u;
			point.v   <= trace.s_v;
			err_u     <= '0;
			err_v     <= '0;
			e_x_q     <= trace.e_x;
			du_q      <= trace.du;
			dv_q      <= trace.dv;
			divisor_q <= trace.divisor;
		end else if (advance) begin
			point.x <= point.x + 1'b1;
			point.u <= u_next;
			point.v <= v_next;
			err_u   <= err_u_next;
			err_v   <= err_v_next;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= TRACE_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Leaves busy when the consumer takes the point that sits on end X
	always_comb begin
		state_next = state;
		case (state)
			TRACE_IDLE: begin
				if (trace_stb) begin
					state_next = TRACE_BUSY;
				end
			end
			TRACE_BUSY: begin
				if (point_ack && last) begin
					state_next = TRACE_IDLE;
				end
			end
			default: begin
				state_next = TRACE_IDLE;
			end
		endcase
	end

	assign trace_ack = (state == TRACE_IDLE);
	assign point_stb = (state == TRACE_BUSY);
	assign busy = (state == TRACE_BUSY);

endmodule

//--- rtl/tmu_scanline.sv
//##########################################################
// Top level of the span rasterizing stage
// Spans enter through a strobe and acknowledge pair, textured
// points leave through another one
//##########################################################

`timescale 1ns/100ps

module tmu_scanline (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      span_stb,
	output logic                      span_ack,
	input  tmu_geom_pkg::tmu_span_t   span,
	output logic                      point_stb,
	input  logic                      point_ack,
	output tmu_geom_pkg::tmu_point_t  point,
	output logic                      busy
);
	import tmu_geom_pkg::*;

	logic       div_start;
	tmu_frac_t  du_dividend;
	tmu_frac_t  dv_dividend;
	tmu_frac_t  divisor;
	tmu_frac_t  du_q;
	tmu_frac_t  du_r;
	tmu_frac_t  dv_q;
	tmu_frac_t  dv_r;
	logic       du_done;
	logic       trace_stb;
	logic       trace_ack;
	tmu_trace_t trace;
	logic       setup_busy;
	logic       trace_busy;

	tmu_span_setup setup (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.span_stb    (span_stb),
		.span_ack    (span_ack),
		.span        (span),
		.div_start   (div_start),
		.du_dividend (du_dividend),
		.dv_dividend (dv_dividend),
		.divisor     (divisor),
		.du_q        (du_q),
		.du_r        (du_r),
		.dv_q        (dv_q),
		.dv_r        (dv_r),
		.div_done    (du_done),
		.trace_stb   (trace_stb),
		.trace_ack   (trace_ack),
		.trace       (trace),
		.busy        (setup_busy)
	);

	// Both dividers share start and divisor, only the dividend differs
	tmu_divider u_div (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.start     (div_start),
		.dividend  (du_dividend),
		.divisor   (divisor),
		.quotient  (du_q),
		.remainder (du_r),
		.done      (du_done)
	);

	// Finishes on the same edge as the U divider, so its done stays open
	tmu_divider v_div (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.start     (div_start),
		.dividend  (dv_dividend),
		.divisor   (divisor),
		.quotient  (dv_q),
		.remainder (dv_r),
		.done      ()
	);

	tmu_scantrace tracer (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.trace_stb (trace_stb),
		.trace_ack (trace_ack),
		.trace     (trace),
		.point_stb (point_stb),
		.point_ack (point_ack),
		.point     (point),
		.busy      (trace_busy)
	);

	// The stage is busy while any span is still in setup or being traced
	assign busy = setup_busy | trace_busy;

endmodule

//--- verif/tb_scanline.sv
//##########################################################
// Testbench for the span rasterizing stage
// Random spans from a fixed seed meet random back-pressure;
// every point is checked against a model of the stepping rule
//##########################################################

`timescale 1ns/100ps
`include "tmu_config.svh"

module tb_scanline;
	import tmu_geom_pkg::*;

	localparam int num_spans = 200;
	localparam int max_len = 40;
	localparam int clk_period = 20;
	// Cycle budget per span, generous for setup, division and up to 41 stalled points
	localparam int span_cycles = 60 + 2 * `TMU_DIV_CYCLES;

	logic       sys_clk;
	logic       sys_rst;
	logic       span_stb;
	logic       span_ack;
	tmu_span_t  span;
	logic       point_stb;
	logic       point_ack;
	tmu_point_t point;
	logic       busy;

	logic [31:0] span_rng;
	logic [31:0] ack_rng;
	tmu_span_t   span_fifo[$];
	tmu_point_t  expect_fifo[$];
	int          spans_checked = 0;

	tmu_scanline UUT (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.span_stb  (span_stb),
		.span_ack  (span_ack),
		.span      (span),
		.point_stb (point_stb),
		.point_ack (point_ack),
		.point     (point),
		.busy      (busy)
	);

	// Numerical Recipes constants for the LCG
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Low bits of an LCG are weak, so draw from the upper ones
	function automatic int pick(input logic [31:0] state, input int range);
		return int'((state >> 8) % 32'(range));
	endfunction

	task automatic draw(input int range, output int val);
		span_rng = lcg_next(span_rng);
		val = pick(span_rng, range);
	endtask

	// Extra unit is due once the non-negative error passes half the span length
	function automatic int take_extra(input int sum, input int len);
		if (sum >= 0 && (sum % 2048) > (len >> 1)) begin
			return 1;
		end else begin
			return 0;
		end
	endfunction

	task automatic check_point(input string name, input tmu_point_t got, input tmu_point_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got x=%0d y=%0d u=%0d v=%0d,",
				$time, name, got.x, got.y, got.u, got.v);
			$display("    expected x=%0d y=%0d u=%0d v=%0d",
				exp.x, exp.y, exp.u, exp.v);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %b, expected %b", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// Random span with e_x >= s_x and all coordinates within 0 to 1023
	// About one span in eight has a flat U slope, likewise for V
	task automatic make_span(input int idx, output tmu_span_t sp);
		int len;
		int sx;
		int y;
		int su;
		int sv;
		int eu;
		int ev;
		int flat;
		draw(max_len + 1, len);
		if (idx % 16 == 3) begin
			len = 0;
		end
		draw(1024 - len, sx);
		draw(1024, y);
		draw(1024, su);
		draw(1024, sv);
		draw(1024, eu);
		draw(1024, ev);
		draw(8, flat);
		if (flat == 0) begin
			eu = su;
		end
		draw(8, flat);
		if (flat == 1) begin
			ev = sv;
		end
		sp.y = y[`TMU_COORD_W-1:0];
		sp.s_x = sx[`TMU_COORD_W-1:0];
		sp.e_x = sx[`TMU_COORD_W-1:0] + len[`TMU_COORD_W-1:0];
		sp.s_u = su[`TMU_COORD_W-1:0];
		sp.s_v = sv[`TMU_COORD_W-1:0];
		sp.e_u = eu[`TMU_COORD_W-1:0];
		sp.e_v = ev[`TMU_COORD_W-1:0];
	endtask

	// Expected points of one span from integer division and the error rule
	task automatic build_expected(input tmu_span_t sp);
		int len;
		int du;
		int dv;
		int q_u;
		int r_u;
		int q_v;
		int r_v;
		int u;
		int v;
		int err_u;
		int err_v;
		int sum;
		int extra;
		int x;
		tmu_point_t p;
		len = int'(sp.e_x) - int'(sp.s_x);
		du = int'(sp.e_u) - int'(sp.s_u);
		dv = int'(sp.e_v) - int'(sp.s_v);
		q_u = 0;
		r_u = 0;
		q_v = 0;
		r_v = 0;
		if (len > 0) begin
			q_u = ((du < 0) ? -du : du) / len;
			r_u = ((du < 0) ? -du : du) % len;
			q_v = ((dv < 0) ? -dv : dv) / len;
			r_v = ((dv < 0) ? -dv : dv) % len;
		end
		u = int'(sp.s_u);
		v = int'(sp.s_v);
		err_u = 0;
		err_v = 0;
		for (int i = 0; i <= len; i++) begin
			x = int'(sp.s_x) + i;
			p.x = x[`TMU_COORD_W-1:0];
			p.y = sp.y;
			p.u = u[`TMU_COORD_W-1:0];
			p.v = v[`TMU_COORD_W-1:0];
			expect_fifo.push_back(p);
			sum = err_u + r_u;
			extra = take_extra(sum, len);
			u = (du < 0) ? u - (q_u + extra) : u + (q_u + extra);
			err_u = (extra != 0) ? sum - len : sum;
			sum = err_v + r_v;
			extra = take_extra(sum, len);
			v = (dv < 0) ? v - (q_v + extra) : v + (q_v + extra);
			err_v = (extra != 0) ? sum - len : sum;
		end
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(num_spans * span_cycles * clk_period);
		$display("Watchdog expired at %0t ns: the run timed out before all spans were checked",
			$time);
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	// Consumer back-pressure, low about a third of the time
	initial begin
		point_ack = 1'b0;
		ack_rng = 32'hdbd1;
		forever begin
			@(posedge sys_clk);
			#1;
			ack_rng = lcg_next(ack_rng);
			point_ack = (pick(ack_rng, 3) != 0);
		end
	end

	// Samples at the falling edge where handshake and point are settled
	initial begin : monitor
		tmu_point_t held;
		tmu_point_t exp_pt;
		tmu_point_t end_pt;
		tmu_span_t  cur;
		logic       holding;
		int         count;
		holding = 1'b0;
		count = 0;
		forever begin
			@(negedge sys_clk);
			if (sys_rst || !point_stb) begin
				holding = 1'b0;
			end else begin
				// A stalled point must not move
				if (holding) begin
					check_point("point while stalled", point, held);
				end
				if (!point_ack) begin
					holding = 1'b1;
					held = point;
				end else if (expect_fifo.size() == 0 || span_fifo.size() == 0) begin
					$display("Error at %0t ns: a point was taken with no expected point pending",
						$time);
					$display("SIMULATION FAILED");
					$fatal(1);
				end else begin
					holding = 1'b0;
					exp_pt = expect_fifo.pop_front();
					cur = span_fifo[0];
					count++;
					// The DUT reaching end X closes the span's count
					if (point.x == cur.e_x) begin
						check_count("points per span", count,
							int'(cur.e_x) - int'(cur.s_x) + 1);
						// A one-pixel span stays on its start texel and a longer one ends on e_u, e_v
						end_pt.x = cur.e_x;
						end_pt.y = cur.y;
						if (cur.e_x == cur.s_x) begin
							end_pt.u = cur.s_u;
							end_pt.v = cur.s_v;
						end else begin
							end_pt.u = cur.e_u;
							end_pt.v = cur.e_v;
						end
						check_point("point at span end", point, end_pt);
					end
					check_point("point", point, exp_pt);
					if (point.x == cur.e_x) begin
						cur = span_fifo.pop_front();
						count = 0;
						spans_checked++;
					end
				end
			end
		end
	end

	initial begin : driver
		tmu_span_t sp;
		int        gap;
		sys_rst = 1'b1;
		span_stb = 1'b0;
		span = '0;
		span_rng = 32'hdbd1;
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		@(negedge sys_clk);
		check_flag("span_ack", span_ack, 1'b1);
		check_flag("point_stb", point_stb, 1'b0);
		check_flag("busy", busy, 1'b0);
		@(posedge sys_clk);
		#1;
		for (int n = 0; n < num_spans; n++) begin
			make_span(n, sp);
			draw(3, gap);
			repeat (gap) begin
				@(posedge sys_clk);
				#1;
			end
			span = sp;
			span_stb = 1'b1;
			@(negedge sys_clk);
			while (!span_ack) @(negedge sys_clk);
			// Taken on this edge
			@(posedge sys_clk);
			span_fifo.push_back(sp);
			build_expected(sp);
			#1;
			span_stb = 1'b0;
			@(negedge sys_clk);
			check_flag("span_ack", span_ack, 1'b0);
			@(posedge sys_clk);
			#1;
		end
		while (spans_checked < num_spans) @(negedge sys_clk);
		// The last acknowledge lands on the next edge and the stage goes quiet
		@(posedge sys_clk);
		@(negedge sys_clk);
		check_flag("busy", busy, 1'b0);
		if (expect_fifo.size() == 0 && span_fifo.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("Error at %0t ns: expected points are left over after the last span", $time);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

endmodule

//--- src.f
+incdir+rtl
rtl/tmu_geom_pkg.sv
rtl/tmu_ctrl_pkg.sv
rtl/tmu_divider.sv
rtl/tmu_span_setup.sv
rtl/tmu_scantrace.sv
rtl/tmu_scanline.sv
verif/tb_scanline.sv

//--- run_sim.sh
#!/bin/sh
# Builds the span rasterizer testbench with Verilator and runs it.
# The exit status is the simulator's, non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_scanline \
	-Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
